// File: Bender.yml
package:
  name: alarm_clock

sources:
  - common/clock_pkg.sv
  - common/disp_pkg.sv
  - src/tick_gen.sv
  - ctrl/button_sync.sv
  - ctrl/clock_ctrl.sv
  - timekeep/time_counter.sv
  - timekeep/timekeeper.sv
  - disp/digit_scan.sv
  - src/alarm_clock_top.sv
  - target: test
    files:
      - dv/tb_alarm_clock.sv

// File: common/clock_pkg.sv
`default_nettype none

package clock_pkg;

	// --------------------------------------------------
	// time fields
	// --------------------------------------------------
	typedef logic [5:0] time_field_t;	// one field, 0..59

	localparam int SEC_MAX = 59;
	localparam int MIN_MAX = 59;
	localparam int HR_MAX  = 23;	// 24-hour form only

	// --------------------------------------------------
	// control state
	// --------------------------------------------------
	typedef enum logic [1:0] {
		MODE_CLOCK     = 2'd0,
		MODE_SET_TIME  = 2'd1,
		MODE_SET_ALARM = 2'd2
	} mode_e;

	// encoding matches digit pair index (scan index / 2)
	typedef enum logic [1:0] {
		FIELD_SEC = 2'd0,
		FIELD_MIN = 2'd1,
		FIELD_HR  = 2'd2
	} field_e;

endpackage

`default_nettype wire

// File: common/disp_pkg.sv
`default_nettype none

package disp_pkg;

	localparam int NUM_DIGITS = 6;

	typedef logic [6:0]            seg_t;	// {a,b,c,d,e,f,g}, active high
	typedef logic [3:0]            bcd_t;
	typedef logic [2:0]            digit_idx_t;
	typedef logic [NUM_DIGITS-1:0] digit_enb_t;	// active low

	// --------------------------------------------------
	// segment patterns
	// --------------------------------------------------
	localparam seg_t SEG_DIGIT [10] = '{
		7'b111_1110,	// 0
		7'b011_0000,	// 1
		7'b110_1101,	// 2
		7'b111_1001,	// 3
		7'b011_0011,	// 4
		7'b101_1011,	// 5
		7'b101_1111,	// 6
		7'b111_0000,	// 7
		7'b111_1111,	// 8
		7'b111_0011	// 9
	};

	localparam seg_t SEG_BLANK = 7'b000_0000;

endpackage

`default_nettype wire

// File: ctrl/button_sync.sv
`timescale 1ns/10ps
`default_nettype none

module button_sync (
	input  logic clk,
	input  logic rst_n,
	input  logic i_sample,
	input  logic i_btn,
	output logic o_press
);

	logic sync_q1, sync_q2;	// metastability chain
	logic sample_q;	// value seen at the previous sample tick
	logic level_q;	// debounced level
	logic level_dly;

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			sync_q1 <= 1'b0;
			sync_q2 <= 1'b0;
		end else begin
			sync_q1 <= i_btn;
			sync_q2 <= sync_q1;
		end
	end

	// --------------------------------------------------
	// debounce over two sample ticks
	// --------------------------------------------------
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			sample_q <= 1'b0;
			level_q  <= 1'b0;
		end else if (i_sample) begin
			sample_q <= sync_q2;
			if (sync_q2 == sample_q) begin
				level_q <= sync_q2;	// stable on two ticks in a row
			end
		end
	end

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			level_dly <= 1'b0;
		end else begin
			level_dly <= level_q;
		end
	end

	assign o_press = level_q & ~level_dly;	// one clk on rising edge

endmodule

`default_nettype wire

// File: ctrl/clock_ctrl.sv
`timescale 1ns/10ps
`default_nettype none

module clock_ctrl (
	input  logic               clk,
	input  logic               rst_n,
	input  logic               i_sec_tick,
	input  logic               i_mode_press,
	input  logic               i_field_press,
	input  logic               i_step_press,
	input  logic               i_alarm_press,
	output clock_pkg::mode_e   o_mode,
	output clock_pkg::field_e  o_field,
	output logic               o_alarm_en,
	output logic               o_run_tick,
	output logic               o_time_step,
	output logic               o_alarm_step
);

	logic set_time, set_alarm;

	// --------------------------------------------------
	// mode FSM
	// --------------------------------------------------
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			o_mode <= clock_pkg::MODE_CLOCK;
		end else if (i_mode_press) begin
			case (o_mode)
				clock_pkg::MODE_CLOCK:    o_mode <= clock_pkg::MODE_SET_TIME;
				clock_pkg::MODE_SET_TIME: o_mode <= clock_pkg::MODE_SET_ALARM;
				default:                  o_mode <= clock_pkg::MODE_CLOCK;
			endcase
		end
	end

	// --------------------------------------------------
	// field FSM
	// --------------------------------------------------
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			o_field <= clock_pkg::FIELD_SEC;
		end else if (i_field_press) begin
			case (o_field)
				clock_pkg::FIELD_SEC: o_field <= clock_pkg::FIELD_MIN;
				clock_pkg::FIELD_MIN: o_field <= clock_pkg::FIELD_HR;
				default:              o_field <= clock_pkg::FIELD_SEC;
			endcase
		end
	end

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			o_alarm_en <= 1'b0;
		end else if (i_alarm_press) begin
			o_alarm_en <= ~o_alarm_en;
		end
	end

	// --------------------------------------------------
	// step steering
	// --------------------------------------------------
	assign set_time  = (o_mode == clock_pkg::MODE_SET_TIME);
	assign set_alarm = (o_mode == clock_pkg::MODE_SET_ALARM);

	assign o_run_tick   = i_sec_tick & ~set_time;	// time frozen while being set
	assign o_time_step  = i_step_press & set_time;
	assign o_alarm_step = i_step_press & set_alarm;

endmodule

`default_nettype wire

// File: disp/digit_scan.sv
`timescale 1ns/10ps
`default_nettype none

module digit_scan (
	input  logic                   clk,
	input  logic                   rst_n,
	input  logic                   i_scan_tick,
	input  clock_pkg::mode_e       i_mode,
	input  clock_pkg::field_e      i_field,
	input  clock_pkg::time_field_t i_sec,
	input  clock_pkg::time_field_t i_min,
	input  clock_pkg::time_field_t i_hr,
	output disp_pkg::seg_t         o_seg,
	output logic                   o_seg_dp,
	output disp_pkg::digit_enb_t   o_seg_enb
);

	localparam disp_pkg::digit_idx_t LAST_IDX =
		disp_pkg::digit_idx_t'(disp_pkg::NUM_DIGITS - 1);

	disp_pkg::digit_idx_t   idx;
	clock_pkg::time_field_t cur_field;	// field of the current digit pair
	disp_pkg::bcd_t         tens, ones, digit;

	// --------------------------------------------------
	// scan position
	// --------------------------------------------------
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			idx <= '0;
		end else if (i_scan_tick) begin
			if (idx == LAST_IDX) begin
				idx <= '0;
			end else begin
				idx <= idx + 1'b1;
			end
		end
	end

	// --------------------------------------------------
	// digit select and BCD split
	// --------------------------------------------------
	// pairs are sec (0,1), min (2,3), hr (4,5); odd index is tens
	always_comb begin
		case (idx[2:1])
			2'd0:    cur_field = i_sec;
			2'd1:    cur_field = i_min;
			2'd2:    cur_field = i_hr;
			default: cur_field = '0;
		endcase
	end

	assign tens  = disp_pkg::bcd_t'(cur_field / 10);
	assign ones  = disp_pkg::bcd_t'(cur_field % 10);
	assign digit = idx[0] ? tens : ones;

	// segment decode
	always_comb begin
		if (digit <= 4'd9) begin
			o_seg = disp_pkg::SEG_DIGIT[digit];
		end else begin
			o_seg = disp_pkg::SEG_BLANK;
		end
	end

	assign o_seg_enb = ~(disp_pkg::digit_enb_t'(1) << idx);	// one low bit

	// decimal points mark the field under edit
	assign o_seg_dp = (i_mode != clock_pkg::MODE_CLOCK) && (2'(i_field) == idx[2:1]);

endmodule

`default_nettype wire

// File: dv/tb_alarm_clock.sv
`timescale 1ns/10ps
`default_nettype none

module tb_alarm_clock;

	localparam int SEC_DIV    = 400;
	localparam int SCAN_DIV   = 4;
	localparam int SAMPLE_DIV = 8;
	localparam int DAY        = 24 * 3600;
	localparam int PRESS_CYC  = 12 * SAMPLE_DIV + 1;	// hold, release and edge wait
	localparam int BTN_MODE   = 0;
	localparam int BTN_FIELD  = 1;
	localparam int BTN_STEP   = 2;
	localparam int BTN_ALARM  = 3;

	// segments a..g, a in the top bit
	localparam logic [6:0] SEG_REF [10] = '{
		7'h7e, 7'h30, 7'h6d, 7'h79, 7'h33, 7'h5b, 7'h5f, 7'h70, 7'h7f, 7'h73
	};

	logic       clk;
	logic       rst_n;
	logic [3:0] btn;
	logic [6:0] seg;
	logic       seg_dp;
	logic [5:0] seg_enb;
	logic       alarm;

	int cyc = 0;
	int errors = 0;
	int checks = 0;
	int tests = 0;
	int test_errs = 0;

	// last steady display read
	int rd_hr, rd_min, rd_sec, rd_cyc;
	logic [5:0] rd_dp;
	logic rd_alarm;

	alarm_clock_top #(
		.SEC_DIV    (SEC_DIV),
		.SCAN_DIV   (SCAN_DIV),
		.SAMPLE_DIV (SAMPLE_DIV)
	) dut_i (
		.clk, .rst_n,
		.i_btn_mode  (btn[BTN_MODE]),
		.i_btn_field (btn[BTN_FIELD]),
		.i_btn_step  (btn[BTN_STEP]),
		.i_btn_alarm (btn[BTN_ALARM]),
		.o_seg       (seg),
		.o_seg_dp    (seg_dp),
		.o_seg_enb   (seg_enb),
		.o_alarm     (alarm)
	);

	initial clk = 1'b0;
	always #50 clk = ~clk;

	always @(posedge clk) cyc <= cyc + 1;

	function automatic int seg_to_digit(input logic [6:0] pattern);
		int d;
		d = 15;	// no match
		for (int i = 0; i < 10; i++) begin
			if (SEG_REF[i] == pattern) d = i;
		end
		return d;
	endfunction

	function automatic int secs_of(input int h, input int m, input int s);
		return h * 3600 + m * 60 + s;
	endfunction

	// --------------------------------------------------
	// display checks on every clock
	// --------------------------------------------------
	assert property (@(posedge clk) disable iff (!rst_n) $onehot(~seg_enb))
		else begin
			errors++;
			$display("CHECK FAILED o_seg_enb: got %h, expected exactly one low bit", seg_enb);
		end

	assert property (@(posedge clk) disable iff (!rst_n) seg_to_digit(seg) < 10)
		else begin
			errors++;
			$display("CHECK FAILED o_seg: got %h, not a digit pattern", seg);
		end

	task automatic timeout_fail(input string what);
		$display("timeout while waiting for %s", what);
		$display("test failed");
		$finish;
	endtask

	task automatic check_eq(input string name, input int got, input int exp);
		checks++;
		assert (got == exp) else begin
			errors++;
			$display("CHECK FAILED %s: got %h expected %h", name, got, exp);
		end
	endtask

	task automatic check_range(input string name, input int got, input int lo, input int hi);
		checks++;
		assert (got >= lo && got <= hi) else begin
			errors++;
			$display("CHECK FAILED %s: got %h expected %h to %h", name, got, lo, hi);
		end
	endtask

	task automatic finish_test(input string name);
		if (errors == test_errs) begin
			$display("%s ... ok", name);
		end else begin
			$display("%s ... FAIL (%0d errors)", name, errors - test_errs);
		end
		test_errs = errors;
		tests++;
	endtask

	task automatic press(input int which);
		@(posedge clk);
		btn[which] <= 1'b1;
		repeat (6 * SAMPLE_DIV) @(posedge clk);
		btn[which] <= 1'b0;
		repeat (6 * SAMPLE_DIV) @(posedge clk);
	endtask

	task automatic step_times(input int n);
		for (int i = 0; i < n; i++) begin
			press(BTN_STEP);
		end
	endtask

	// one pass over digits 0..5, value packed as decimal hhmmss
	task automatic read_once(output int val, output logic [5:0] dp, output logic alm,
			output int start);
		int guard;
		int pow;
		logic [5:0] want;
		val = 0;
		pow = 1;
		dp = '0;
		for (int i = 0; i < 6; i++) begin
			guard = 0;
			want = ~(6'b000001 << i);
			while (seg_enb != want) begin
				@(negedge clk);
				guard++;
				if (guard > 8 * SCAN_DIV) timeout_fail("a digit enable");
			end
			if (i == 0) begin
				start = cyc;
				alm = alarm;
			end
			val += seg_to_digit(seg) * pow;
			pow *= 10;
			dp[i] = seg_dp;
		end
	endtask

	// two passes must agree so a tick in mid-scan is not mistaken for a value
	task automatic read_display();
		int va, vb, sa, sb;
		logic [5:0] da, db;
		logic aa, ab;
		@(negedge clk);
		for (int n = 0; n < 10; n++) begin
			read_once(va, da, aa, sa);
			read_once(vb, db, ab, sb);
			if (va == vb && da == db) begin
				rd_sec = va % 100;
				rd_min = (va / 100) % 100;
				rd_hr = va / 10000;
				rd_dp = da;
				rd_alarm = aa;
				rd_cyc = sa;
				return;
			end
		end
		timeout_fail("a steady display");
	endtask

	// k is a multiple of 3, so scan phase and second phase both repeat
	task automatic advance_and_check(input int k);
		int t0, c0, exp_t, guard;
		t0 = secs_of(rd_hr, rd_min, rd_sec);
		c0 = rd_cyc;
		exp_t = (t0 + k) % DAY;
		guard = 0;
		while (cyc != c0 + k * SEC_DIV - 1) begin
			@(negedge clk);
			guard++;
			if (guard > (k + 2) * SEC_DIV) timeout_fail("the next read slot");
		end
		read_display();
		check_eq("o_seg hours", rd_hr, exp_t / 3600);
		check_eq("o_seg minutes", rd_min, (exp_t / 60) % 60);
		check_eq("o_seg seconds", rd_sec, exp_t % 60);
	endtask

	initial begin
		int k, t_a, n_steps, r, a_hr, frozen_t, frozen_cyc;
		int t_now, ahead, tgt, need, p_hr, p_min, p_sec, guard;
		btn = '0;
		rst_n = 1'b0;
		void'($urandom(69367));
		repeat (10) @(posedge clk);
		rst_n <= 1'b1;

		// --------------------------------------------------
		// reset and running time
		// --------------------------------------------------
		read_display();
		check_eq("o_seg time", secs_of(rd_hr, rd_min, rd_sec), 0);
		check_eq("o_seg_dp", rd_dp, 0);
		check_eq("o_alarm", alarm, 0);
		finish_test("reset state");

		read_display();
		k = 3 * (1 + $urandom % 3);
		advance_and_check(k);
		k = 3 * ((60 - rd_sec + 2) / 3);	// lands past 59, carry into minutes
		advance_and_check(k);
		finish_test("running time");

		// --------------------------------------------------
		// set time, frozen while editing
		// --------------------------------------------------
		press(BTN_MODE);
		read_display();
		t_a = secs_of(rd_hr, rd_min, rd_sec);
		repeat (3 * SEC_DIV) @(negedge clk);
		read_display();
		check_eq("o_seg frozen time", secs_of(rd_hr, rd_min, rd_sec), t_a);
		check_eq("o_seg_dp", rd_dp, 6'b000011);
		press(BTN_FIELD);
		read_display();
		check_eq("o_seg_dp", rd_dp, 6'b001100);
		// enough steps to pass 59, so a stray carry into hours would show
		n_steps = 60 - (t_a / 60) % 60 + $urandom % 20;
		step_times(n_steps);
		read_display();
		check_eq("o_seg hours", rd_hr, t_a / 3600);
		check_eq("o_seg minutes", rd_min, ((t_a / 60) % 60 + n_steps) % 60);
		check_eq("o_seg seconds", rd_sec, t_a % 60);
		frozen_t = secs_of(rd_hr, rd_min, rd_sec);
		frozen_cyc = cyc;
		finish_test("set time");

		// --------------------------------------------------
		// set alarm
		// --------------------------------------------------
		press(BTN_MODE);
		read_display();
		check_eq("o_seg alarm time", secs_of(rd_hr, rd_min, rd_sec), 0);
		check_eq("o_seg_dp", rd_dp, 6'b001100);
		press(BTN_FIELD);
		step_times(23);
		read_display();
		check_eq("o_seg alarm hours", rd_hr, 23);
		check_eq("o_seg_dp", rd_dp, 6'b110000);
		r = $urandom % 3;
		step_times(1 + r);
		read_display();
		check_eq("o_seg alarm time", secs_of(rd_hr, rd_min, rd_sec), r * 3600);
		a_hr = r;
		press(BTN_MODE);
		read_display();
		check_range("o_seg elapsed seconds",
			(secs_of(rd_hr, rd_min, rd_sec) - frozen_t + DAY) % DAY,
			0, (cyc - frozen_cyc) / SEC_DIV + 1);
		check_eq("o_seg_dp", rd_dp, 0);
		finish_test("set alarm");

		// --------------------------------------------------
		// alarm match and clear
		// --------------------------------------------------
		read_display();
		t_now = secs_of(rd_hr, rd_min, rd_sec);
		ahead = 4;
		for (int it = 0; it < 8; it++) begin
			tgt = (t_now + ahead) % DAY;
			p_hr = (tgt / 3600 - a_hr + 24) % 24;
			need = ((p_hr + (tgt / 60) % 60 + tgt % 60 + 6) * PRESS_CYC) / SEC_DIV + 4;
			if (need > ahead) ahead = need;	// setup time eats into the lead
		end
		tgt = (t_now + ahead) % DAY;
		p_hr = (tgt / 3600 - a_hr + 24) % 24;
		p_min = (tgt / 60) % 60;
		p_sec = tgt % 60;
		press(BTN_MODE);
		press(BTN_MODE);
		step_times(p_hr);
		press(BTN_FIELD);	// hr to sec
		step_times(p_sec);
		press(BTN_FIELD);
		step_times(p_min);
		press(BTN_MODE);
		press(BTN_ALARM);
		guard = 0;
		read_display();
		while (secs_of(rd_hr, rd_min, rd_sec) != tgt) begin
			check_eq("o_alarm", rd_alarm, 0);
			guard++;
			if (guard > 40 * ahead) timeout_fail("the time to reach the alarm");
			read_display();
		end
		guard = 0;
		while (!alarm && guard < SEC_DIV) begin
			@(negedge clk);
			guard++;
		end
		check_eq("o_alarm", alarm, 1);
		press(BTN_ALARM);
		@(negedge clk);
		check_eq("o_alarm", alarm, 0);
		finish_test("alarm");

		$display("tests: %0d, checks: %0d, errors: %0d", tests, checks, errors);
		if (errors == 0) begin
			$display("test passed");
		end else begin
			$display("test failed");
		end
		$finish;
	end

endmodule

`default_nettype wire

// File: filelist.f
common/clock_pkg.sv
common/disp_pkg.sv
src/tick_gen.sv
ctrl/button_sync.sv
ctrl/clock_ctrl.sv
timekeep/time_counter.sv
timekeep/timekeeper.sv
disp/digit_scan.sv
src/alarm_clock_top.sv
dv/tb_alarm_clock.sv

// File: src/alarm_clock_top.sv
`timescale 1ns/10ps
`default_nettype none

module alarm_clock_top #(
	parameter int SEC_DIV    = 50_000_000,
	parameter int SCAN_DIV   = 2_500,
	parameter int SAMPLE_DIV = 500_000
) (
	input  logic                clk,
	input  logic                rst_n,
	input  logic                i_btn_mode,
	input  logic                i_btn_field,
	input  logic                i_btn_step,
	input  logic                i_btn_alarm,
	output disp_pkg::seg_t      o_seg,
	output logic                o_seg_dp,
	output disp_pkg::digit_enb_t o_seg_enb,
	output logic                o_alarm
);

	logic sec_tick, scan_tick, sample_tick;
	logic mode_press, field_press, step_press, alarm_press;
	logic alarm_en, run_tick, time_step, alarm_step;

	clock_pkg::mode_e       mode;
	clock_pkg::field_e      field;
	clock_pkg::time_field_t disp_sec, disp_min, disp_hr;

	// --------------------------------------------------
	// timebases
	// --------------------------------------------------
	tick_gen #(.DIV(SEC_DIV))    u_sec_tick    (.clk, .rst_n, .o_tick(sec_tick));
	tick_gen #(.DIV(SCAN_DIV))   u_scan_tick   (.clk, .rst_n, .o_tick(scan_tick));
	tick_gen #(.DIV(SAMPLE_DIV)) u_sample_tick (.clk, .rst_n, .o_tick(sample_tick));

	// --------------------------------------------------
	// buttons
	// --------------------------------------------------
	button_sync u_btn_mode  (.clk, .rst_n, .i_sample(sample_tick), .i_btn(i_btn_mode),
		.o_press(mode_press));
	button_sync u_btn_field (.clk, .rst_n, .i_sample(sample_tick), .i_btn(i_btn_field),
		.o_press(field_press));
	button_sync u_btn_step  (.clk, .rst_n, .i_sample(sample_tick), .i_btn(i_btn_step),
		.o_press(step_press));
	button_sync u_btn_alarm (.clk, .rst_n, .i_sample(sample_tick), .i_btn(i_btn_alarm),
		.o_press(alarm_press));

	clock_ctrl u_ctrl (
		.clk, .rst_n,
		.i_sec_tick    (sec_tick),
		.i_mode_press  (mode_press),
		.i_field_press (field_press),
		.i_step_press  (step_press),
		.i_alarm_press (alarm_press),
		.o_mode        (mode),
		.o_field       (field),
		.o_alarm_en    (alarm_en),
		.o_run_tick    (run_tick),
		.o_time_step   (time_step),
		.o_alarm_step  (alarm_step)
	);

	timekeeper u_time (
		.clk, .rst_n,
		.i_mode       (mode),
		.i_field      (field),
		.i_alarm_en   (alarm_en),
		.i_run_tick   (run_tick),
		.i_time_step  (time_step),
		.i_alarm_step (alarm_step),
		.o_disp_sec   (disp_sec),
		.o_disp_min   (disp_min),
		.o_disp_hr    (disp_hr),
		.o_alarm      (o_alarm)
	);

	digit_scan u_scan (
		.clk, .rst_n,
		.i_scan_tick (scan_tick),
		.i_mode      (mode),
		.i_field     (field),
		.i_sec       (disp_sec),
		.i_min       (disp_min),
		.i_hr        (disp_hr),
		.o_seg       (o_seg),
		.o_seg_dp    (o_seg_dp),
		.o_seg_enb   (o_seg_enb)
	);

endmodule

`default_nettype wire

// File: src/tick_gen.sv
`timescale 1ns/10ps
`default_nettype none

module tick_gen #(
	parameter int DIV = 50_000_000
) (
	input  logic clk,
	input  logic rst_n,
	output logic o_tick
);

	localparam int W = (DIV > 1) ? $clog2(DIV) : 1;
	localparam logic [W-1:0] RELOAD = W'(DIV - 1);

	logic [W-1:0] cnt;

	// down-counter, pulse registered so the first one lands DIV cycles in
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			cnt    <= RELOAD;
			o_tick <= 1'b0;
		end else begin
			o_tick <= (cnt == '0);
			if (cnt == '0) begin
				cnt <= RELOAD;
			end else begin
				cnt <= cnt - 1'b1;
			end
		end
	end

endmodule

`default_nettype wire

// File: timekeep/time_counter.sv
`timescale 1ns/10ps
`default_nettype none

module time_counter #(
	parameter int MAX = 59
) (
	input  logic                   clk,
	input  logic                   rst_n,
	input  logic                   i_step,
	output clock_pkg::time_field_t o_value,
	output logic                   o_wrap
);

	localparam clock_pkg::time_field_t LAST = clock_pkg::time_field_t'(MAX);

	// carry out, valid in the same cycle as the step
	assign o_wrap = i_step && (o_value == LAST);

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			o_value <= '0;
		end else if (i_step) begin
			if (o_value == LAST) begin
				o_value <= '0;
			end else begin
				o_value <= o_value + 1'b1;
			end
		end
	end

endmodule

`default_nettype wire

// File: timekeep/timekeeper.sv
`timescale 1ns/10ps
`default_nettype none

module timekeeper (
	input  logic                   clk,
	input  logic                   rst_n,
	input  clock_pkg::mode_e       i_mode,
	input  clock_pkg::field_e      i_field,
	input  logic                   i_alarm_en,
	input  logic                   i_run_tick,
	input  logic                   i_time_step,
	input  logic                   i_alarm_step,
	output clock_pkg::time_field_t o_disp_sec,
	output clock_pkg::time_field_t o_disp_min,
	output clock_pkg::time_field_t o_disp_hr,
	output logic                   o_alarm
);

	logic sel_sec, sel_min, sel_hr;
	logic sec_step, min_step, hr_step;
	logic sec_wrap, min_wrap;
	logic match;

	clock_pkg::time_field_t sec, min, hr;
	clock_pkg::time_field_t alm_sec, alm_min, alm_hr;

	assign sel_sec = (i_field == clock_pkg::FIELD_SEC);
	assign sel_min = (i_field == clock_pkg::FIELD_MIN);
	assign sel_hr  = (i_field == clock_pkg::FIELD_HR);

	// --------------------------------------------------
	// running time
	// --------------------------------------------------
	// carries only ride on the run tick, manual steps never carry
	assign sec_step = i_run_tick | (i_time_step & sel_sec);
	assign min_step = (sec_wrap & i_run_tick) | (i_time_step & sel_min);
	assign hr_step  = (min_wrap & i_run_tick) | (i_time_step & sel_hr);

	time_counter #(.MAX(clock_pkg::SEC_MAX)) u_sec (.clk, .rst_n,
		.i_step(sec_step), .o_value(sec), .o_wrap(sec_wrap));
	time_counter #(.MAX(clock_pkg::MIN_MAX)) u_min (.clk, .rst_n,
		.i_step(min_step), .o_value(min), .o_wrap(min_wrap));
	time_counter #(.MAX(clock_pkg::HR_MAX)) u_hr (.clk, .rst_n,
		.i_step(hr_step), .o_value(hr), .o_wrap());	// day rollover unused

	// --------------------------------------------------
	// alarm time
	// --------------------------------------------------
	time_counter #(.MAX(clock_pkg::SEC_MAX)) u_alm_sec (.clk, .rst_n,
		.i_step(i_alarm_step & sel_sec), .o_value(alm_sec), .o_wrap());
	time_counter #(.MAX(clock_pkg::MIN_MAX)) u_alm_min (.clk, .rst_n,
		.i_step(i_alarm_step & sel_min), .o_value(alm_min), .o_wrap());
	time_counter #(.MAX(clock_pkg::HR_MAX)) u_alm_hr (.clk, .rst_n,
		.i_step(i_alarm_step & sel_hr), .o_value(alm_hr), .o_wrap());

	// show alarm only while editing it
	always_comb begin
		if (i_mode == clock_pkg::MODE_SET_ALARM) begin
			o_disp_sec = alm_sec;
			o_disp_min = alm_min;
			o_disp_hr  = alm_hr;
		end else begin
			o_disp_sec = sec;
			o_disp_min = min;
			o_disp_hr  = hr;
		end
	end

	// --------------------------------------------------
	// alarm latch
	// --------------------------------------------------
	assign match = (sec == alm_sec) && (min == alm_min) && (hr == alm_hr);

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			o_alarm <= 1'b0;
		end else begin
			o_alarm <= i_alarm_en & (o_alarm | match);	// held until disabled
		end
	end

endmodule

`default_nettype wire
